//--- src/fsqrt_pkg.sv
package fsqrt_pkg;

    // ==================================================
    // word and field widths
    // ==================================================

    localparam int word_bits = 32;
    localparam int exp_bits  = 8;
    localparam int frac_bits = 23;

    // root significand carries the hidden one above the fraction
    localparam int root_bits = frac_bits + 1;

    // radicand holds two bits per root bit
    localparam int rad_bits = 2 * root_bits;

    // two guard bits keep the running remainder in range
    localparam int rem_bits = root_bits + 2;

    // ==================================================
    // shared types
    // ==================================================

    typedef logic [exp_bits-1:0] exp_t;
    typedef logic [root_bits-1:0] root_t;
    typedef logic signed [rem_bits-1:0] rem_t;
    typedef logic [rad_bits-1:0] rad_t;

    // bias of 127 halved and rounded down, the lost half comes back from the exponent lsb
    localparam exp_t half_bias = 8'd63;

    // one IEEE single word, seen either raw or split into its fields
    typedef union packed {
        logic [word_bits-1:0] raw;
        struct packed {
            logic                sign;
            logic [exp_bits-1:0] exp;
            logic [frac_bits-1:0] frac;
        } f;
    } float_word_u;

endpackage

//--- src/sqrt_operand_decode.sv
`timescale 1ns/100ps

module sqrt_operand_decode (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             valid_in,
    input  logic [fsqrt_pkg::word_bits-1:0]  radicand,
    output logic                             dec_valid,
    output fsqrt_pkg::exp_t                  dec_exp,
    output fsqrt_pkg::rad_t                  dec_rad
);

    localparam int pad_bits = fsqrt_pkg::rad_bits - fsqrt_pkg::root_bits - 1;

    fsqrt_pkg::float_word_u word;
    fsqrt_pkg::exp_t        half_exp;
    fsqrt_pkg::rad_t        aligned;

    assign word = radicand;

    // ==================================================
    // exponent halving and significand alignment
    // ==================================================

    // an odd biased exponent is an even true exponent and halves cleanly
    assign half_exp = {1'b0, word.f.exp[fsqrt_pkg::exp_bits-1:1]}
                    + fsqrt_pkg::half_bias
                    + fsqrt_pkg::exp_t'(word.f.exp[0]);

    always_comb begin
        if (word.f.exp[0]) begin
            aligned = {1'b0, 1'b1, word.f.frac, {pad_bits{1'b0}}};
        end else begin
            // doubling the significand absorbs the odd true exponent
            aligned = {1'b1, word.f.frac, 1'b0, {pad_bits{1'b0}}};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= valid_in;
        end
    end

    // last operand is held through idle cycles
    always_ff @(posedge clk) begin
        if (valid_in) begin
            dec_exp <= half_exp;
            dec_rad <= aligned;
        end
    end

    // zero and subnormal inputs are outside the supported range
    assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid |-> ($past(word.f.exp) != '0))
        else $error("operand with zero exponent field entered the pipeline");

endmodule

//--- src/sqrt_recurrence_stage.sv
`timescale 1ns/100ps

module sqrt_recurrence_stage #(
    parameter int bits_per_stage = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  fsqrt_pkg::exp_t   in_exp,
    input  fsqrt_pkg::rem_t   in_rem,
    input  fsqrt_pkg::root_t  in_root,
    input  fsqrt_pkg::rad_t   in_rad,
    output logic              out_valid,
    output fsqrt_pkg::exp_t   out_exp,
    output fsqrt_pkg::rem_t   out_rem,
    output fsqrt_pkg::root_t  out_root,
    output fsqrt_pkg::rad_t   out_rad
);

    localparam int rem_msb  = fsqrt_pkg::rem_bits - 1;
    localparam int root_msb = fsqrt_pkg::root_bits - 1;
    localparam int rad_msb  = fsqrt_pkg::rad_bits - 1;

    fsqrt_pkg::rem_t  nxt_rem;
    fsqrt_pkg::root_t nxt_root;
    fsqrt_pkg::rad_t  nxt_rad;

    // ==================================================
    // non-restoring iterations, unrolled within the cycle
    // ==================================================

    always_comb begin : iterate
        fsqrt_pkg::rem_t  r;
        fsqrt_pkg::root_t q;
        fsqrt_pkg::rad_t  d;
        r = in_rem;
        q = in_root;
        d = in_rad;
        for (int i = 0; i < bits_per_stage; i++) begin
            // the sign of the old remainder picks subtract or add
            // top bits may wrap but the result always fits back into rem_bits
            if (r >= 0) begin
                r = {r[rem_msb-2:0], d[rad_msb -: 2]} - {q, 2'b01};
            end else begin
                r = {r[rem_msb-2:0], d[rad_msb -: 2]} + {q, 2'b11};
            end
            q = {q[root_msb-1:0], ~r[rem_msb]};
            d = d << 2;
        end
        nxt_rem  = r;
        nxt_root = q;
        nxt_rad  = d;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_exp  <= in_exp;
        out_rem  <= nxt_rem;
        out_root <= nxt_root;
        out_rad  <= nxt_rad;
    end

    assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(out_valid))
        else $error("stage valid is unknown after reset");

endmodule

//--- src/sqrt_digit_pipeline.sv
`timescale 1ns/100ps

module sqrt_digit_pipeline #(
    parameter int bits_per_stage = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              dec_valid,
    input  fsqrt_pkg::exp_t   dec_exp,
    input  fsqrt_pkg::rad_t   dec_rad,
    output logic              pipe_valid,
    output fsqrt_pkg::exp_t   pipe_exp,
    output fsqrt_pkg::root_t  pipe_root
);

    localparam int num_stages = fsqrt_pkg::root_bits / bits_per_stage;

    // index 0 is the seed, index s+1 is the output of stage s
    wire                    chain_valid [0:num_stages];
    wire fsqrt_pkg::exp_t   chain_exp   [0:num_stages];
    wire fsqrt_pkg::rem_t   chain_rem   [0:num_stages];
    wire fsqrt_pkg::root_t  chain_root  [0:num_stages];
    wire fsqrt_pkg::rad_t   chain_rad   [0:num_stages];

    // ==================================================
    // seed and stage chain
    // ==================================================

    assign chain_valid[0] = dec_valid;
    assign chain_exp[0]   = dec_exp;
    assign chain_rem[0]   = '0;
    assign chain_root[0]  = '0;
    assign chain_rad[0]   = dec_rad;

    // every stage must resolve the same number of root bits
    if (fsqrt_pkg::root_bits % bits_per_stage != 0) begin : g_bad_split
        $error("bits_per_stage must divide the root width evenly");
    end

    for (genvar s = 0; s < num_stages; s++) begin : g_stage
        sqrt_recurrence_stage #(
            .bits_per_stage (bits_per_stage)
        ) u_stage (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (chain_valid[s]),
            .in_exp    (chain_exp[s]),
            .in_rem    (chain_rem[s]),
            .in_root   (chain_root[s]),
            .in_rad    (chain_rad[s]),
            .out_valid (chain_valid[s+1]),
            .out_exp   (chain_exp[s+1]),
            .out_rem   (chain_rem[s+1]),
            .out_root  (chain_root[s+1]),
            .out_rad   (chain_rad[s+1])
        );
    end

    // ==================================================
    // last stage feeds the result packing
    // ==================================================

    // no correction step, so the final remainder goes nowhere
    assign pipe_valid = chain_valid[num_stages];
    assign pipe_exp   = chain_exp[num_stages];
    assign pipe_root  = chain_root[num_stages];

endmodule

//--- src/sqrt_result_pack.sv
`timescale 1ns/100ps

module sqrt_result_pack (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             pipe_valid,
    input  fsqrt_pkg::exp_t                  pipe_exp,
    input  fsqrt_pkg::root_t                 pipe_root,
    output logic                             valid_out,
    output logic [fsqrt_pkg::word_bits-1:0]  y
);

    // ==================================================
    // output word and strobe
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
            y         <= '0;
        end else begin
            valid_out <= pipe_valid;
            // hidden one is dropped, sign is always positive
            if (pipe_valid) begin
                y <= {1'b0, pipe_exp, pipe_root[fsqrt_pkg::frac_bits-1:0]};
            end
        end
    end

    // a normal radicand aligned in decode always yields a root in [1, 2)
    assert property (@(posedge clk) disable iff (!rst_n)
        pipe_valid |-> pipe_root[fsqrt_pkg::root_bits-1])
        else $error("root leading bit is zero at the pipeline output");

endmodule

//--- src/fsqrt_top.sv
`timescale 1ns/100ps

module fsqrt_top #(
    parameter int bits_per_stage = 2
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             valid_in,
    input  logic [fsqrt_pkg::word_bits-1:0]  radicand,
    output logic                             valid_out,
    output logic [fsqrt_pkg::word_bits-1:0]  y
);

    // decode to recurrence pipeline
    logic              dec_valid;
    fsqrt_pkg::exp_t   dec_exp;
    fsqrt_pkg::rad_t   dec_rad;

    // recurrence pipeline to result packing
    logic              pipe_valid;
    fsqrt_pkg::exp_t   pipe_exp;
    fsqrt_pkg::root_t  pipe_root;

    // ==================================================
    // operand capture, digit recurrence, result word
    // ==================================================

    sqrt_operand_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .radicand  (radicand),
        .dec_valid (dec_valid),
        .dec_exp   (dec_exp),
        .dec_rad   (dec_rad)
    );

    sqrt_digit_pipeline #(
        .bits_per_stage (bits_per_stage)
    ) u_pipeline (
        .clk        (clk),
        .rst_n      (rst_n),
        .dec_valid  (dec_valid),
        .dec_exp    (dec_exp),
        .dec_rad    (dec_rad),
        .pipe_valid (pipe_valid),
        .pipe_exp   (pipe_exp),
        .pipe_root  (pipe_root)
    );

    sqrt_result_pack u_pack (
        .clk        (clk),
        .rst_n      (rst_n),
        .pipe_valid (pipe_valid),
        .pipe_exp   (pipe_exp),
        .pipe_root  (pipe_root),
        .valid_out  (valid_out),
        .y          (y)
    );

endmodule

//--- test/fsqrt_model.svh
`ifndef FSQRT_MODEL_SVH
`define FSQRT_MODEL_SVH

// 32-bit linear congruential step, the upper bits are the useful ones
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
endfunction

// truncated square root of a normal single, sign ignored
function automatic logic [fsqrt_pkg::word_bits-1:0] model_fsqrt(
    input logic [fsqrt_pkg::word_bits-1:0] word
);
    fsqrt_pkg::float_word_u w;
    fsqrt_pkg::float_word_u r;
    logic [23:0] sig;
    logic [47:0] rad;
    logic [47:0] sq;
    logic [23:0] root;
    logic [23:0] trial;
    w.raw = word;
    sig = {1'b1, w.f.frac};
    // odd biased exponent keeps the significand, even doubles it
    if (w.f.exp[0]) begin
        rad = {24'd0, sig} << 23;
    end else begin
        rad = {24'd0, sig} << 24;
    end
    // largest 24-bit root whose square does not exceed the radicand
    root = '0;
    for (int i = 23; i >= 0; i--) begin
        trial = root | (24'd1 << i);
        sq = trial * trial;
        if (sq <= rad) begin
            root = trial;
        end
    end
    r.f.sign = 1'b0;
    r.f.exp = {1'b0, w.f.exp[7:1]} + fsqrt_pkg::half_bias + {7'd0, w.f.exp[0]};
    r.f.frac = root[22:0];
    return r.raw;
endfunction

`endif

//--- test/tb_fsqrt.sv
`timescale 1ns/100ps

module tb_fsqrt;

    `include "fsqrt_model.svh"

    localparam int latency      = fsqrt_pkg::root_bits / 2 + 2;
    localparam int reset_cycles = 3;
    localparam int num_exact    = 4;
    localparam int burst_len    = 50;
    localparam int num_random   = 2000;
    localparam int max_gap      = 3;
    localparam int margin       = 200;
    localparam int cycle_limit  = reset_cycles + num_exact * (latency + 3) + burst_len + latency
                                + num_random * (max_gap + 1) + latency + margin;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        valid_in;
    logic [31:0] radicand;
    logic        valid_out;
    logic [31:0] y;

    logic [31:0] seed;
    logic [31:0] expected_q[$];
    int          issue_q[$];
    logic [31:0] held_y;
    int          in_count;
    int          out_count;
    int          cycle;

    fsqrt_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .radicand  (radicand),
        .valid_out (valid_out),
        .y         (y)
    );

    always #10 clk = ~clk;

    task automatic report_failure(input string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
        $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, want);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic send_word(input logic [31:0] w);
        @(posedge clk);
        valid_in <= 1'b1;
        radicand <= w;
        in_count++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            valid_in <= 1'b0;
        end
    endtask

    // random normal operand with a random sign, exponent kept in 1..254
    task automatic random_operand(output logic [31:0] w);
        logic [31:0] r1;
        logic [31:0] r2;
        seed = lcg_next(seed);
        r1 = seed;
        seed = lcg_next(seed);
        r2 = seed;
        w = {r1[31], 8'd1 + (r1[23:16] % 8'd254), r2[31:9]};
    endtask

    task automatic check_exact(input logic [31:0] w, input logic [31:0] want);
        send_word(w);
        idle_cycles(1);
        do @(negedge clk); while (valid_out !== 1'b1);
        assert (y == want) else value_mismatch("y", y, want);
    endtask

    // ==================================================
    // scoreboard and output monitor
    // ==================================================

    always @(negedge clk) begin : monitor
        logic [31:0] want;
        int born;
        if (!rst_n) begin
            assert (valid_out == 1'b0) else report_failure("valid_out went high during reset");
            assert (y == '0) else value_mismatch("y", y, '0);
        end else begin
            if (valid_in) begin
                expected_q.push_back(model_fsqrt(radicand));
                issue_q.push_back(cycle);
            end
            if (valid_out) begin
                assert (expected_q.size() != 0)
                    else report_failure("valid_out pulsed with no operand outstanding");
                want = expected_q.pop_front();
                born = issue_q.pop_front();
                out_count++;
                assert (y == want) else value_mismatch("y", y, want);
                assert (y[31] == 1'b0) else value_mismatch("y sign", {31'd0, y[31]}, '0);
                assert (cycle - born == latency)
                    else report_failure($sformatf("result came %0d cycles after its operand, not %0d",
                                                  cycle - born, latency));
                held_y = y;
            end else begin
                assert (y == held_y) else value_mismatch("y", y, held_y);
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            report_failure($sformatf("run did not finish within %0d cycles", cycle_limit));
        end
    end

    // ==================================================
    // stimulus
    // ==================================================

    initial begin : stimulus
        logic [31:0] w;
        rst_n = 1'b0;
        valid_in = 1'b0;
        radicand = '0;
        seed = 32'd80131;
        held_y = '0;
        in_count = 0;
        out_count = 0;
        cycle = 0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;

        // exact squares of 1.0, 4.0, 2.25 and 0.25
        check_exact(32'h3F80_0000, 32'h3F80_0000);
        check_exact(32'h4080_0000, 32'h4000_0000);
        check_exact(32'h4010_0000, 32'h3FC0_0000);
        check_exact(32'h3E80_0000, 32'h3F00_0000);

        // back-to-back burst with one operand per cycle
        repeat (burst_len) begin
            random_operand(w);
            send_word(w);
        end
        idle_cycles(latency + 2);

        // random operands separated by random idle gaps
        for (int i = 0; i < num_random; i++) begin
            random_operand(w);
            send_word(w);
            seed = lcg_next(seed);
            idle_cycles(seed[31:24] % (max_gap + 1));
        end

        // the pipeline has a fixed depth, so every result is out after this drain
        idle_cycles(latency + 2);
        @(negedge clk);

        assert (out_count == in_count)
            else report_failure($sformatf("%0d operands went in but %0d results came out",
                                          in_count, out_count));
        assert (expected_q.size() == 0) else report_failure("scoreboard queue is not empty");
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- project.f
+incdir+test
src/fsqrt_pkg.sv
src/sqrt_operand_decode.sv
src/sqrt_recurrence_stage.sv
src/sqrt_digit_pipeline.sv
src/sqrt_result_pack.sv
src/fsqrt_top.sv
test/tb_fsqrt.sv
